// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_tlp_frag
FILELIST   ?= verilog.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
FAIL_MSG   ?= Test failures found
PASS_MSG   ?= All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not complete"; exit 1; fi
	@echo "simulation passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== logic/frag_pkg.sv ====
`default_nettype none

package frag_pkg;

    localparam int entry_w         = 128;                       // four dwords per entry
    localparam int max_tlp_entries = 9;
    localparam int tlp_w           = entry_w * max_tlp_entries;
    localparam int fifo_depth      = 32;                        // power of two, pointers wrap
    localparam int addr_w          = $clog2(fifo_depth);
    localparam int count_w         = $clog2(fifo_depth + 1);    // holds 0 .. fifo_depth
    localparam int len_w           = $clog2(max_tlp_entries + 1);

    // read opcode of the fifo
    typedef enum logic {
        rd_one = 1'b0,  // one entry, lo only
        rd_two = 1'b1   // two entries, lo then hi
    } rd_mode_t;

endpackage

`default_nettype wire

// ==== logic/frag_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

module frag_reader (
    input  wire                           clk,
    input  wire                           arst,
    input  wire  [frag_pkg::count_w-1:0]  count,
    input  wire                           pair_en,
    output logic                          rd_en,
    output frag_pkg::rd_mode_t            rd_mode,
    output logic                          frag_valid,
    output logic                          frag_two
);

    // read whatever is there, pairs when allowed
    always_comb begin
        rd_en   = 1'b0;
        rd_mode = frag_pkg::rd_one;
        if (pair_en && (count >= frag_pkg::count_w'(2))) begin
            rd_en   = 1'b1;
            rd_mode = frag_pkg::rd_two;
        end else if (count != '0) begin
            rd_en   = 1'b1;                 // single entry left or pairing off
        end
    end

    // one cycle behind the read, lines up with fifo read data
    always_ff @(posedge clk or negedge arst) begin
        if (!arst) begin
            frag_valid <= 1'b0;
            frag_two   <= 1'b0;
        end else begin
            frag_valid <= rd_en;
            frag_two   <= rd_en && (rd_mode == frag_pkg::rd_two);
        end
    end

endmodule

`default_nettype wire

// ==== logic/tlp_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module tlp_fifo (
    input  wire                            clk,
    input  wire                            arst,
    input  wire                            wr_en,
    input  wire  [frag_pkg::len_w-1:0]     wr_len,
    input  wire  [frag_pkg::tlp_w-1:0]     wr_data,
    input  wire                            rd_en,
    input  wire  frag_pkg::rd_mode_t       rd_mode,
    output logic [frag_pkg::entry_w-1:0]   rd_data_lo,
    output logic [frag_pkg::entry_w-1:0]   rd_data_hi,
    output logic [frag_pkg::count_w-1:0]   count,
    output logic                           empty
);

    logic [frag_pkg::entry_w-1:0] mem [frag_pkg::fifo_depth];
    logic [frag_pkg::addr_w-1:0]  wr_addr;
    logic [frag_pkg::addr_w-1:0]  rd_addr;
    logic                         wr_lap;   // flips each time wr_addr wraps
    logic                         rd_lap;
    logic [1:0]                   rd_step;
    logic [frag_pkg::count_w-1:0] wr_add;
    logic [frag_pkg::count_w-1:0] rd_sub;

    assign rd_step = (rd_mode == frag_pkg::rd_two) ? 2'd2 : 2'd1;
    assign wr_add  = wr_en ? frag_pkg::count_w'(wr_len) : '0;
    assign rd_sub  = rd_en ? frag_pkg::count_w'(rd_step) : '0;

    // same address, same lap means nothing stored
    assign empty = (wr_addr == rd_addr) && (wr_lap == rd_lap);

    always_ff @(posedge clk or negedge arst) begin
        if (!arst) begin
            wr_addr <= '0;
            rd_addr <= '0;
            wr_lap  <= 1'b0;
            rd_lap  <= 1'b0;
            count   <= '0;
        end else begin
            if (wr_en) begin
                {wr_lap, wr_addr} <= {wr_lap, wr_addr}
                                     + (frag_pkg::addr_w + 1)'(wr_len);
            end
            if (rd_en) begin
                {rd_lap, rd_addr} <= {rd_lap, rd_addr}
                                     + (frag_pkg::addr_w + 1)'(rd_step);
            end
            count <= count + wr_add - rd_sub;  // write and read in one edge
        end
    end

    // entry 0 comes from the top slice of wr_data
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int k = 0; k < frag_pkg::max_tlp_entries; k++) begin
                if (k < int'(wr_len)) begin
                    mem[wr_addr + frag_pkg::addr_w'(k)] <=
                        wr_data[frag_pkg::tlp_w - 1 - k * frag_pkg::entry_w -: frag_pkg::entry_w];
                end
            end
        end
        if (rd_en) begin
            rd_data_lo <= mem[rd_addr];
            if (rd_mode == frag_pkg::rd_two) begin
                rd_data_hi <= mem[rd_addr + frag_pkg::addr_w'(1)];  // next entry, wraps
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/tlp_frag_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tlp_frag_top (
    input  wire                            clk,
    input  wire                            arst,
    input  wire                            tlp_valid,
    input  wire  [frag_pkg::tlp_w-1:0]     tlp_data,
    input  wire  [frag_pkg::len_w-1:0]     tlp_len,
    input  wire                            pair_en,
    output logic                           tlp_drop,
    output logic                           frag_valid,
    output logic [frag_pkg::entry_w-1:0]   frag_lo,
    output logic [frag_pkg::entry_w-1:0]   frag_hi,
    output logic                           frag_two,
    output logic                           empty
);

    // writer to fifo
    logic                          wr_en;
    logic [frag_pkg::len_w-1:0]    wr_len;
    logic [frag_pkg::tlp_w-1:0]    wr_data;

    // fifo status, seen by both sides
    logic [frag_pkg::count_w-1:0]  count;

    // reader to fifo
    logic                          rd_en;
    frag_pkg::rd_mode_t            rd_mode;

    tlp_writer u_writer (
        .clk       (clk),
        .arst      (arst),
        .tlp_valid (tlp_valid),
        .tlp_data  (tlp_data),
        .tlp_len   (tlp_len),
        .count     (count),
        .wr_en     (wr_en),
        .wr_len    (wr_len),
        .wr_data   (wr_data),
        .tlp_drop  (tlp_drop)
    );

    tlp_fifo u_fifo (
        .clk        (clk),
        .arst       (arst),
        .wr_en      (wr_en),
        .wr_len     (wr_len),
        .wr_data    (wr_data),
        .rd_en      (rd_en),
        .rd_mode    (rd_mode),
        .rd_data_lo (frag_lo),      // registered, valid with frag_valid
        .rd_data_hi (frag_hi),
        .count      (count),
        .empty      (empty)
    );

    frag_reader u_reader (
        .clk        (clk),
        .arst       (arst),
        .count      (count),
        .pair_en    (pair_en),
        .rd_en      (rd_en),
        .rd_mode    (rd_mode),
        .frag_valid (frag_valid),
        .frag_two   (frag_two)
    );

endmodule

`default_nettype wire

// ==== logic/tlp_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module tlp_writer (
    input  wire                           clk,
    input  wire                           arst,
    input  wire                           tlp_valid,
    input  wire  [frag_pkg::tlp_w-1:0]    tlp_data,
    input  wire  [frag_pkg::len_w-1:0]    tlp_len,
    input  wire  [frag_pkg::count_w-1:0]  count,
    output logic                          wr_en,
    output logic [frag_pkg::len_w-1:0]    wr_len,
    output logic [frag_pkg::tlp_w-1:0]    wr_data,
    output logic                          tlp_drop
);

    logic [frag_pkg::count_w-1:0] pending;      // accepted last edge, not in count yet
    logic [frag_pkg::count_w-1:0] free_space;
    logic                         fits;

    assign pending = wr_en ? frag_pkg::count_w'(wr_len) : '0;

    // count plus pending never passes fifo_depth, so no underflow here
    assign free_space = frag_pkg::count_w'(frag_pkg::fifo_depth) - count - pending;
    assign fits       = frag_pkg::count_w'(tlp_len) <= free_space;

    // decision made at the capture edge, strobes last one cycle
    always_ff @(posedge clk or negedge arst) begin
        if (!arst) begin
            wr_en    <= 1'b0;
            tlp_drop <= 1'b0;
        end else begin
            wr_en    <= tlp_valid && fits;
            tlp_drop <= tlp_valid && !fits;  // whole tlp discarded
        end
    end

    always_ff @(posedge clk) begin
        if (tlp_valid && fits) begin
            wr_data <= tlp_data;
            wr_len  <= tlp_len;
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_tlp_frag.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_tlp_frag;

    localparam int cw              = frag_pkg::entry_w;
    localparam int num_tlps        = 60;                       // per random test
    localparam int watchdog_cycles = (3 * num_tlps + 1) * 20 + 500;

    logic                         clk;
    logic                         arst;
    logic                         tlp_valid;
    logic [frag_pkg::tlp_w-1:0]   tlp_data;
    logic [frag_pkg::len_w-1:0]   tlp_len;
    logic                         pair_en;
    logic                         tlp_drop;
    logic                         frag_valid;
    logic [cw-1:0]                frag_lo;
    logic [cw-1:0]                frag_hi;
    logic                         frag_two;
    logic                         empty;

    integer seed = 32'heef3;
    string  test_name = "none";
    int     fail_count = 0;
    int     drop_count = 0;
    int     drops_before;
    int     lat;
    bit     check_en = 1'b0;

    // model state, values after the latest edge
    logic [cw-1:0] q[$];
    logic [cw-1:0] pend [frag_pkg::max_tlp_entries];
    int            pend_len;
    bit            pend_v;
    int            m_count;
    bit            m_drop;
    bit            m_frag_valid;
    bit            m_frag_two;
    logic [cw-1:0] m_lo;
    logic [cw-1:0] m_hi;

    tlp_frag_top uut (
        .clk        (clk),
        .arst       (arst),
        .tlp_valid  (tlp_valid),
        .tlp_data   (tlp_data),
        .tlp_len    (tlp_len),
        .pair_en    (pair_en),
        .tlp_drop   (tlp_drop),
        .frag_valid (frag_valid),
        .frag_lo    (frag_lo),
        .frag_hi    (frag_hi),
        .frag_two   (frag_two),
        .empty      (empty)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check(input string what, input logic [cw-1:0] expected,
                         input logic [cw-1:0] actual);
        if (expected !== actual) begin
            fail_count++;
            $display("FAILED %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
            $display("Test failures found");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // cycle model, inputs read before the edge updates them
    always @(posedge clk) begin : model_step
        int free;
        int step;
        if (!arst) begin
            q.delete();
            pend_v       = 1'b0;
            pend_len     = 0;
            m_count      = 0;
            m_drop       = 1'b0;
            m_frag_valid = 1'b0;
            m_frag_two   = 1'b0;
        end else begin
            free = frag_pkg::fifo_depth - m_count - (pend_v ? pend_len : 0);  // reads not credited
            step = 0;
            if (pair_en && m_count >= 2) begin
                step = 2;
            end else if (m_count >= 1) begin
                step = 1;
            end
            m_frag_valid = (step != 0);
            m_frag_two   = (step == 2);
            if (step >= 1) m_lo = q.pop_front();
            if (step == 2) m_hi = q.pop_front();
            if (pend_v) begin                          // last capture lands now
                for (int k = 0; k < pend_len; k++) q.push_back(pend[k]);
            end
            m_count = m_count + (pend_v ? pend_len : 0) - step;
            pend_v  = 1'b0;
            m_drop  = 1'b0;
            if (tlp_valid) begin
                if (int'(tlp_len) <= free) begin
                    pend_v   = 1'b1;
                    pend_len = int'(tlp_len);
                    // entry 0 is the top slice
                    for (int k = 0; k < pend_len; k++) begin
                        pend[k] = tlp_data[(frag_pkg::max_tlp_entries - 1 - k) * cw +: cw];
                    end
                end else begin
                    m_drop = 1'b1;
                end
            end
        end
    end

    // outputs are settled mid cycle
    always @(negedge clk) begin
        if (check_en) begin
            check("tlp_drop", cw'(m_drop), cw'(tlp_drop));
            check("frag_valid", cw'(m_frag_valid), cw'(frag_valid));
            check("empty", cw'(m_count == 0), cw'(empty));
            check("count", cw'(m_count), cw'(uut.u_fifo.count));
            if (m_frag_valid) begin
                check("frag_two", cw'(m_frag_two), cw'(frag_two));
                check("frag_lo", m_lo, frag_lo);
                if (m_frag_two) check("frag_hi", m_hi, frag_hi);
            end
            if (tlp_drop) drop_count++;     // drops seen at the dut output
        end
    end

    task automatic drive_tlp(input int len);
        logic [frag_pkg::tlp_w-1:0] data;
        for (int i = 0; i < frag_pkg::tlp_w / 32; i++) begin
            data[i * 32 +: 32] = $random(seed);
        end
        @(posedge clk);
        tlp_valid <= 1'b1;
        tlp_len   <= frag_pkg::len_w'(len);
        tlp_data  <= data;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            tlp_valid <= 1'b0;
        end
    endtask

    task automatic send_random(input int n);
        int len;
        int gap;
        for (int i = 0; i < n; i++) begin
            len = 1 + ({$random(seed)} % frag_pkg::max_tlp_entries);
            gap = {$random(seed)} % 4;        // zero means back to back
            drive_tlp(len);
            idle(gap);
        end
        idle(1);
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while ((m_count != 0 || pend_v) && cycles < 200) begin
            @(negedge clk);
            cycles++;
        end
        check("drained", cw'(1), cw'(m_count == 0 && !pend_v));
    endtask

    initial begin
        tlp_valid <= 1'b0;
        tlp_data  <= '0;
        tlp_len   <= '0;
        pair_en   <= 1'b0;
        arst      <= 1'b0;
        repeat (3) @(posedge clk);
        arst <= 1'b1;

        test_name = "reset";
        @(negedge clk);
        check("empty", cw'(1), cw'(empty));
        check("frag_valid", cw'(0), cw'(frag_valid));
        check("tlp_drop", cw'(0), cw'(tlp_drop));
        check_en = 1'b1;

        test_name = "single_drain";
        send_random(num_tlps);
        wait_drain();

        test_name = "paired_drain";
        @(posedge clk);
        pair_en <= 1'b1;
        send_random(num_tlps);
        wait_drain();

        test_name = "overflow";
        @(posedge clk);
        pair_en <= 1'b0;
        drops_before = drop_count;
        repeat (num_tlps) drive_tlp(frag_pkg::max_tlp_entries);
        idle(1);
        wait_drain();
        check("drops seen", cw'(1), cw'(drop_count > drops_before));

        test_name = "latency";
        drive_tlp(1 + ({$random(seed)} % frag_pkg::max_tlp_entries));
        idle(1);
        lat = 1;                               // one edge since the strobe
        @(negedge clk);
        while (!frag_valid && lat < 20) begin
            @(posedge clk);
            lat++;
            @(negedge clk);
        end
        check("cycles to frag_valid", cw'(3), cw'(lat));
        wait_drain();
        check("empty after drain", cw'(1), cw'(empty));

        if (fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Watchdog expired before the tests finished");
        $display("Test failures found");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

// ==== tb/tlp_frag_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module tlp_frag_props (
    input wire                           clk,
    input wire                           arst,
    input wire                           rd_en,
    input wire frag_pkg::rd_mode_t       rd_mode,
    input wire [frag_pkg::count_w-1:0]   count,
    input wire                           empty
);

    // occupancy never beyond the memory
    count_in_range: assert property (@(posedge clk) disable iff (!arst)
        count <= frag_pkg::count_w'(frag_pkg::fifo_depth))
        else $error("fifo count above depth");

    read_not_empty: assert property (@(posedge clk) disable iff (!arst)
        rd_en |-> count != '0)   // nothing to read
        else $error("read while fifo count is zero");

    pair_needs_two: assert property (@(posedge clk) disable iff (!arst)
        (rd_en && rd_mode == frag_pkg::rd_two) |-> count >= frag_pkg::count_w'(2))
        else $error("paired read with fewer than two entries");

    // pointer view and count view agree
    empty_matches_count: assert property (@(posedge clk) disable iff (!arst)
        empty == (count == '0))
        else $error("empty flag disagrees with count");

endmodule

bind tlp_fifo tlp_frag_props u_props (
    .clk     (clk),
    .arst    (arst),
    .rd_en   (rd_en),
    .rd_mode (rd_mode),
    .count   (count),
    .empty   (empty)
);

`default_nettype wire

// ==== verilog.f ====
logic/frag_pkg.sv
logic/tlp_writer.sv
logic/tlp_fifo.sv
logic/frag_reader.sv
logic/tlp_frag_top.sv
tb/tlp_frag_props.sv
tb/tb_tlp_frag.sv
